// File: verilog/alu_pkg.sv
package alu_pkg;

    localparam int DATA_W = 32;

    typedef enum logic [4:0] {
        // logic
        alu_and           = 5'd0,
        alu_or            = 5'd1,
        alu_nor           = 5'd2,
        alu_xor           = 5'd3,
        // arithmetic
        alu_add           = 5'd4,
        alu_addu          = 5'd5,
        alu_sub           = 5'd6,
        alu_subu          = 5'd7,
        alu_slt           = 5'd8,
        alu_sltu          = 5'd9,
        // shift amount from src_a
        alu_sll           = 5'd10,
        alu_srl           = 5'd11,
        alu_sra           = 5'd12,
        // shift amount from the sa field
        alu_sll_sa        = 5'd13,
        alu_srl_sa        = 5'd14,
        alu_sra_sa        = 5'd15,
        alu_lui           = 5'd16,
        alu_pass          = 5'd17,
        // multi-cycle engines
        alu_signed_div    = 5'd18,
        alu_unsigned_div  = 5'd19,
        alu_signed_mult   = 5'd20,
        alu_unsigned_mult = 5'd21,
        // hi/lo writes
        alu_mthi          = 5'd22,
        alu_mtlo          = 5'd23
    } alu_op_e;

    function automatic logic is_div_op(input alu_op_e op);
        return (op == alu_signed_div) || (op == alu_unsigned_div);
    endfunction

    function automatic logic is_mult_op(input alu_op_e op);
        return (op == alu_signed_mult) || (op == alu_unsigned_mult);
    endfunction

    // only these two report signed overflow
    function automatic logic is_trap_arith(input alu_op_e op);
        return (op == alu_add) || (op == alu_sub);
    endfunction

endpackage

// File: verilog/alu_simple.sv
`timescale 1ns/1ps

module alu_simple (
    input  logic [alu_pkg::DATA_W-1:0] src_a,
    input  logic [alu_pkg::DATA_W-1:0] src_b,
    input  logic [4:0]                 sa,
    input  alu_pkg::alu_op_e           op,
    output logic [alu_pkg::DATA_W-1:0] simple_result,
    output logic                       add_carry
);
    import alu_pkg::*;

    logic [DATA_W:0]   wide_sum;   // 33 bits, sign extended
    logic [DATA_W:0]   wide_diff;
    logic [4:0]        var_sh;

    assign var_sh    = src_a[4:0];
    assign wide_sum  = {src_a[DATA_W-1], src_a} + {src_b[DATA_W-1], src_b};
    assign wide_diff = {src_a[DATA_W-1], src_a} - {src_b[DATA_W-1], src_b};

    always_comb begin
        add_carry     = 1'b0;
        simple_result = '0;
        case (op)
            alu_and:  simple_result = src_a & src_b;
            alu_or:   simple_result = src_a | src_b;
            alu_nor:  simple_result = ~(src_a | src_b);
            alu_xor:  simple_result = src_a ^ src_b;
            alu_add: begin
                simple_result = wide_sum[DATA_W-1:0];
                add_carry     = wide_sum[DATA_W];
            end
            alu_addu: simple_result = src_a + src_b;
            alu_sub: begin
                simple_result = wide_diff[DATA_W-1:0];
                add_carry     = wide_diff[DATA_W];
            end
            alu_subu: simple_result = src_a - src_b;
            alu_slt: begin
                simple_result = {{(DATA_W-1){1'b0}}, $signed(src_a) < $signed(src_b)};
            end
            alu_sltu: begin
                simple_result = {{(DATA_W-1){1'b0}}, src_a < src_b};
            end
            alu_sll:    simple_result = src_b << var_sh;
            alu_srl:    simple_result = src_b >> var_sh;
            alu_sra:    simple_result = $signed(src_b) >>> var_sh;
            alu_sll_sa: simple_result = src_b << sa;
            alu_srl_sa: simple_result = src_b >> sa;
            alu_sra_sa: simple_result = $signed(src_b) >>> sa;
            alu_lui: begin
                simple_result = {src_b[DATA_W/2-1:0], {(DATA_W/2){1'b0}}};
            end
            alu_pass: simple_result = src_a;
            // engine and hi/lo codes land here
            default: begin
                simple_result = '0;
                add_carry     = 1'b0;
            end
        endcase
    end

endmodule

// File: verilog/div_radix2.sv
`timescale 1ns/1ps

module div_radix2 (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       flush,
    input  logic                       div_start,
    input  logic                       div_signed,
    input  logic [alu_pkg::DATA_W-1:0] src_a,
    input  logic [alu_pkg::DATA_W-1:0] src_b,
    output logic                       div_ready,
    output logic [2*alu_pkg::DATA_W-1:0] div_result
);
    import alu_pkg::*;

    logic              busy;
    logic [5:0]        iter_cnt;   // shift-subtract steps done
    logic [DATA_W-1:0] rem;
    logic [DATA_W-1:0] quo;
    logic [DATA_W-1:0] dvs;
    logic              neg_q;
    logic              neg_r;
    logic              dvs_zero;

    logic              a_neg;
    logic              b_neg;
    logic [DATA_W-1:0] a_mag;
    logic [DATA_W-1:0] b_mag;
    logic [2*DATA_W-1:0] first_step;
    logic [2*DATA_W-1:0] next_step;
    logic [DATA_W-1:0] quo_fixed;
    logic [DATA_W-1:0] rem_fixed;

    // one restoring step, returns {rem, quo}
    function automatic logic [2*DATA_W-1:0] div_step(
        input logic [DATA_W-1:0] r,
        input logic [DATA_W-1:0] q,
        input logic [DATA_W-1:0] d
    );
        logic [DATA_W:0] shifted;
        logic [DATA_W:0] diff;
        shifted = {r, q[DATA_W-1]};
        diff    = shifted - {1'b0, d};
        if (!diff[DATA_W])
            return {diff[DATA_W-1:0], q[DATA_W-2:0], 1'b1};
        return {shifted[DATA_W-1:0], q[DATA_W-2:0], 1'b0};
    endfunction

    assign a_neg = div_signed & src_a[DATA_W-1];
    assign b_neg = div_signed & src_b[DATA_W-1];
    assign a_mag = a_neg ? -src_a : src_a;
    assign b_mag = b_neg ? -src_b : src_b;

    // first step is folded into the capture cycle
    assign first_step = div_step('0, a_mag, b_mag);
    assign next_step  = div_step(rem, quo, dvs);

    assign quo_fixed = dvs_zero ? '1 : (neg_q ? -quo : quo);
    assign rem_fixed = neg_r ? -rem : rem;   // remainder follows the dividend

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            busy      <= 1'b0;
            iter_cnt  <= '0;
            div_ready <= 1'b0;
        end else begin
            div_ready <= 1'b0;
            if (div_start) begin
                busy     <= 1'b1;
                iter_cnt <= 6'd1;
            end else if (busy) begin
                if (iter_cnt == 6'd32) begin
                    busy      <= 1'b0;
                    div_ready <= 1'b1;
                end else begin
                    iter_cnt <= iter_cnt + 6'd1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            {rem, quo} <= first_step;
            dvs        <= b_mag;
            neg_q      <= a_neg ^ b_neg;
            neg_r      <= a_neg;
            dvs_zero   <= (src_b == '0);
        end else if (busy && iter_cnt != 6'd32) begin
            {rem, quo} <= next_step;
        end
        if (busy && iter_cnt == 6'd32)
            div_result <= {rem_fixed, quo_fixed};   // held until next start
    end

endmodule

// File: verilog/mult_pipe.sv
`timescale 1ns/1ps

module mult_pipe #(
    parameter int MULT_STAGES = 5
) (
    input  logic                         clk,
    input  logic                         mult_ce,
    input  logic                         mult_signed,
    input  logic [alu_pkg::DATA_W-1:0]   src_a,
    input  logic [alu_pkg::DATA_W-1:0]   src_b,
    output logic [2*alu_pkg::DATA_W-1:0] mult_result
);
    import alu_pkg::*;

    logic [DATA_W:0]     a_ext;   // 33 bits
    logic [DATA_W:0]     b_ext;
    logic [2*DATA_W+1:0] full_prod;
    logic [2*DATA_W-1:0] stage_q [MULT_STAGES];

    // the extra bit makes one signed multiplier serve both modes
    assign a_ext = {mult_signed & src_a[DATA_W-1], src_a};
    assign b_ext = {mult_signed & src_b[DATA_W-1], src_b};

    assign full_prod = $signed(a_ext) * $signed(b_ext);

    // plain register chain so synthesis can retime the multiplier into it
    always_ff @(posedge clk) begin
        if (mult_ce) begin
            stage_q[0] <= full_prod[2*DATA_W-1:0];
            for (int i = 1; i < MULT_STAGES; i++) begin
                stage_q[i] <= stage_q[i-1];
            end
        end
    end

    assign mult_result = stage_q[MULT_STAGES-1];

endmodule

// File: verilog/exec_alu.sv
`timescale 1ns/1ps

module exec_alu #(
    parameter int MULT_STAGES = 5
) (
    input  logic                         clk,
    input  logic                         rst,
    input  logic                         flush,
    input  logic                         stall_d,
    input  logic                         is_div_d,
    input  logic                         is_mult_d,
    input  logic [alu_pkg::DATA_W-1:0]   src_a,
    input  logic [alu_pkg::DATA_W-1:0]   src_b,
    input  alu_pkg::alu_op_e             op,
    input  logic [4:0]                   sa,
    input  logic [2*alu_pkg::DATA_W-1:0] hilo,
    output logic                         div_stall,
    output logic                         mult_stall,
    output logic                         overflow,
    output logic [2*alu_pkg::DATA_W-1:0] result
);
    import alu_pkg::*;

    localparam int CNT_W = $clog2(MULT_STAGES + 1);

    logic [DATA_W-1:0]   simple_result;
    logic                add_carry;
    logic                div_issue;
    logic                div_start;
    logic                div_signed;
    logic                div_ready;
    logic [2*DATA_W-1:0] div_result;
    logic                mult_issue;
    logic                mult_ce;
    logic                mult_signed;
    logic [2*DATA_W-1:0] mult_result;
    logic [CNT_W-1:0]    mult_cnt;

    alu_simple u_alu_simple (
        .src_a         (src_a),
        .src_b         (src_b),
        .sa            (sa),
        .op            (op),
        .simple_result (simple_result),
        .add_carry     (add_carry)
    );

    assign div_issue  = is_div_d & ~stall_d & ~flush;
    assign div_signed = (op == alu_signed_div);

    always_ff @(posedge clk) begin
        if (rst) begin
            div_stall <= 1'b0;
            div_start <= 1'b0;
        end else begin
            div_start <= div_issue;   // operands reach E next cycle
            if (div_issue)
                div_stall <= 1'b1;
            else if (div_ready || flush)
                div_stall <= 1'b0;
        end
    end

    div_radix2 u_div_radix2 (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .div_start  (div_start),
        .div_signed (div_signed),
        .src_a      (src_a),
        .src_b      (src_b),
        .div_ready  (div_ready),
        .div_result (div_result)
    );

    assign mult_issue  = is_mult_d & ~stall_d & ~flush;
    assign mult_signed = (op == alu_signed_mult);

    always_ff @(posedge clk) begin
        if (rst || flush || mult_issue)
            mult_cnt <= '0;
        else if (mult_cnt != CNT_W'(MULT_STAGES))
            mult_cnt <= mult_cnt + 1'b1;   // saturates at MULT_STAGES
    end

    assign mult_stall = is_mult_op(op) && (mult_cnt < CNT_W'(MULT_STAGES));
    assign mult_ce    = mult_stall;

    mult_pipe #(
        .MULT_STAGES (MULT_STAGES)
    ) u_mult_pipe (
        .clk         (clk),
        .mult_ce     (mult_ce),
        .mult_signed (mult_signed),
        .src_a       (src_a),
        .src_b       (src_b),
        .mult_result (mult_result)
    );

    always_comb begin
        if (is_div_op(op))
            result = div_result;
        else if (is_mult_op(op))
            result = mult_result;
        else if (op == alu_mthi)
            result = {src_a, hilo[DATA_W-1:0]};
        else if (op == alu_mtlo)
            result = {hilo[2*DATA_W-1:DATA_W], src_a};   // hi kept as is
        else
            result = {{DATA_W{1'b0}}, simple_result};
    end

    assign overflow = is_trap_arith(op) & (add_carry ^ simple_result[DATA_W-1]);

endmodule

// File: verification/exec_alu_tb.sv
`timescale 1ns/1ps

module exec_alu_tb;
    import alu_pkg::*;

    localparam int MULT_STAGES = 5;
    localparam int CLK_PERIOD  = 20;
    localparam int NUM_OPS     = 200;
    localparam int OP_CYCLES   = 40;

    logic                clk;
    logic                rst;
    logic                flush;
    logic                stall_d;
    logic                is_div_d;
    logic                is_mult_d;
    logic [DATA_W-1:0]   src_a;
    logic [DATA_W-1:0]   src_b;
    alu_op_e             op;
    logic [4:0]          sa;
    logic [2*DATA_W-1:0] hilo;
    logic                div_stall;
    logic                mult_stall;
    logic                overflow;
    logic [2*DATA_W-1:0] result;

    integer              seed;
    logic [DATA_W-1:0]   ra;
    logic [DATA_W-1:0]   rb;
    logic [2*DATA_W-1:0] held;

    exec_alu #(
        .MULT_STAGES (MULT_STAGES)
    ) u_exec_alu (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .stall_d    (stall_d),
        .is_div_d   (is_div_d),
        .is_mult_d  (is_mult_d),
        .src_a      (src_a),
        .src_b      (src_b),
        .op         (op),
        .sa         (sa),
        .hilo       (hilo),
        .div_stall  (div_stall),
        .mult_stall (mult_stall),
        .overflow   (overflow),
        .result     (result)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD/2) clk = ~clk;
    end

    task automatic stop_with_error(input string what);
        $display("ERROR: %s", what);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic report_mismatch(input string name, input logic [63:0] expected,
                                   input logic [63:0] actual);
        $display("FAIL %s expected 0x%h got 0x%h", name, expected, actual);
        $display("Simulation FAILED");
        $fatal(1);
    endtask

    task automatic check_equal(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual === expected) else report_mismatch(name, expected, actual);
    endtask

    // overflow may only come from the two trapping ops
    ovf_only_trap_ops: assert property (@(posedge clk) disable iff (rst)
        (op != alu_add && op != alu_sub) |-> !overflow)
        else report_mismatch("overflow", 64'd0, {63'b0, $sampled(overflow)});

    initial begin
        #(NUM_OPS * OP_CYCLES * CLK_PERIOD);
        stop_with_error("timeout, the tests did not finish in time");
    end

    function automatic logic [31:0] model_simple(input alu_op_e o, input logic [31:0] a,
                                                 input logic [31:0] b, input logic [4:0] s);
        case (o)
            alu_and:            return a & b;
            alu_or:             return a | b;
            alu_nor:            return ~(a | b);
            alu_xor:            return a ^ b;
            alu_add, alu_addu:  return a + b;
            alu_sub, alu_subu:  return a - b;
            alu_slt:            return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            alu_sltu:           return (a < b) ? 32'd1 : 32'd0;
            alu_sll:            return b << a[4:0];
            alu_srl:            return b >> a[4:0];
            alu_sra:            return $signed(b) >>> a[4:0];
            alu_sll_sa:         return b << s;
            alu_srl_sa:         return b >> s;
            alu_sra_sa:         return $signed(b) >>> s;
            alu_lui:            return {b[15:0], 16'h0000};
            alu_pass:           return a;
            default:            return 32'h0;
        endcase
    endfunction

    // same operand signs but a result of the other sign
    function automatic logic model_ovf(input alu_op_e o, input logic [31:0] a,
                                       input logic [31:0] b);
        logic [31:0] r;
        if (o == alu_add) begin
            r = a + b;
            return (a[31] == b[31]) && (r[31] != a[31]);
        end
        if (o == alu_sub) begin
            r = a - b;
            return (a[31] != b[31]) && (r[31] != a[31]);
        end
        return 1'b0;
    endfunction

    function automatic logic [63:0] model_mult(input alu_op_e o, input logic [31:0] a,
                                               input logic [31:0] b);
        logic signed [63:0] a64;
        logic signed [63:0] b64;
        if (o == alu_signed_mult) begin
            a64 = $signed(a);
            b64 = $signed(b);
            return a64 * b64;
        end
        return {32'h0, a} * {32'h0, b};
    endfunction

    // {remainder, quotient}
    function automatic logic [63:0] model_div(input alu_op_e o, input logic [31:0] a,
                                              input logic [31:0] b);
        logic [31:0] q;
        logic [31:0] r;
        if (b == 32'h0) begin
            q = 32'hffff_ffff;
            r = a;
        end else if (o == alu_signed_div) begin
            q = $signed(a) / $signed(b);
            r = $signed(a) % $signed(b);   // takes the dividend's sign
        end else begin
            q = a / b;
            r = a % b;
        end
        return {r, q};
    endfunction

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic check_simple(input alu_op_e o, input logic [31:0] a, input logic [31:0] b,
                                input logic [4:0] s);
        op    = o;
        src_a = a;
        src_b = b;
        sa    = s;
        #2;
        check_equal("result", {32'h0, model_simple(o, a, b, s)}, result);
        check_equal("overflow", {63'b0, model_ovf(o, a, b)}, {63'b0, overflow});
        step();
    endtask

    task automatic check_hilo_move(input alu_op_e o, input logic [31:0] a,
                                   input logic [63:0] h);
        logic [63:0] expected;
        op    = o;
        src_a = a;
        hilo  = h;
        expected = (o == alu_mthi) ? {a, h[31:0]} : {h[63:32], a};
        #2;
        check_equal("result", expected, result);
        step();
    endtask

    task automatic run_mult(input alu_op_e o, input logic [31:0] a, input logic [31:0] b);
        int n;
        is_mult_d = 1'b1;
        step();   // issue edge
        is_mult_d = 1'b0;
        op    = o;
        src_a = a;
        src_b = b;
        #2;
        n = 0;
        while (mult_stall) begin
            n++;
            if (n > OP_CYCLES)
                stop_with_error("mult_stall never dropped");
            step();
        end
        check_equal("mult_stall", 64'(MULT_STAGES), 64'(n));
        check_equal("result", model_mult(o, a, b), result);
    endtask

    task automatic run_div(input alu_op_e o, input logic [31:0] a, input logic [31:0] b);
        int n;
        is_div_d = 1'b1;
        step();
        is_div_d = 1'b0;
        op    = o;
        src_a = a;
        src_b = b;
        #2;
        n = 0;
        while (div_stall) begin
            n++;
            if (n > 2 * OP_CYCLES)
                stop_with_error("div_stall never dropped");
            step();
        end
        check_equal("div_stall", 64'd34, 64'(n));   // cycles from issue to fall
        check_equal("result", model_div(o, a, b), result);
    endtask

    initial begin
        rst       = 1'b1;
        flush     = 1'b0;
        stall_d   = 1'b0;
        is_div_d  = 1'b0;
        is_mult_d = 1'b0;
        src_a     = '0;
        src_b     = '0;
        op        = alu_pass;
        sa        = '0;
        hilo      = '0;
        seed      = 32'h8951_af1a;
        held      = '0;
        repeat (3) step();
        rst = 1'b0;
        #2;
        check_equal("div_stall", 64'd0, {63'b0, div_stall});
        check_equal("mult_stall", 64'd0, {63'b0, mult_stall});
        step();

        for (int round = 0; round < 4; round++) begin
            for (int k = 0; k <= int'(alu_pass); k++) begin
                check_simple(alu_op_e'(k), $random(seed), $random(seed), 5'($random(seed)));
            end
        end

        check_simple(alu_add, 32'h7fff_ffff, 32'h0000_0001, 5'd0);   // max + 1
        check_simple(alu_addu, 32'h7fff_ffff, 32'h0000_0001, 5'd0);
        check_simple(alu_sub, 32'h8000_0000, 32'h0000_0001, 5'd0);   // min - 1
        check_simple(alu_subu, 32'h8000_0000, 32'h0000_0001, 5'd0);
        check_simple(alu_add, 32'h8000_0000, 32'h8000_0000, 5'd0);
        check_simple(alu_sub, 32'h7fff_ffff, 32'hffff_ffff, 5'd0);
        check_simple(alu_sub, 32'hffff_ffff, 32'h7fff_ffff, 5'd0);
        check_simple(alu_add, 32'hffff_ffff, 32'h0000_0001, 5'd0);
        repeat (6) begin
            check_simple(alu_add, $random(seed), $random(seed), 5'd0);
            check_simple(alu_addu, $random(seed), $random(seed), 5'd0);
            check_simple(alu_sub, $random(seed), $random(seed), 5'd0);
            check_simple(alu_subu, $random(seed), $random(seed), 5'd0);
        end

        repeat (4) begin
            check_hilo_move(alu_mthi, $random(seed), {$random(seed), $random(seed)});
            check_hilo_move(alu_mtlo, $random(seed), {$random(seed), $random(seed)});
        end

        // consecutive calls put the next issue right after the previous result
        run_mult(alu_signed_mult, $random(seed), $random(seed));
        run_mult(alu_unsigned_mult, $random(seed), $random(seed));
        run_mult(alu_signed_mult, 32'h8000_0000, 32'h8000_0000);
        run_mult(alu_signed_mult, 32'hffff_ffff, 32'h0000_0003);
        run_mult(alu_unsigned_mult, 32'hffff_ffff, 32'hffff_ffff);

        repeat (3) begin
            ra = $random(seed);
            rb = $random(seed);
            if (ra == 32'h8000_0000 && rb == 32'hffff_ffff)
                rb = 32'd3;   // quotient would not fit
            run_div(alu_signed_div, ra, rb);
            run_div(alu_unsigned_div, $random(seed), $random(seed));
        end
        run_div(alu_signed_div, 32'hffff_fff9, 32'h0000_0002);
        run_div(alu_signed_div, 32'h0000_0007, 32'hffff_fffe);
        run_div(alu_signed_div, 32'hffff_fff9, 32'hffff_fffe);
        run_div(alu_unsigned_div, 32'hffff_fff9, 32'h0000_0002);
        run_div(alu_signed_div, 32'hffff_fff9, 32'h0000_0000);
        run_div(alu_unsigned_div, 32'h1234_5678, 32'h0000_0000);
        run_div(alu_unsigned_div, 32'h0000_0005, 32'h0000_0009);

        // flush in the middle of a divide
        held = result;
        is_div_d = 1'b1;
        step();
        is_div_d = 1'b0;
        op    = alu_unsigned_div;
        src_a = 32'hdead_beef;
        src_b = 32'h0000_0007;
        repeat (10) step();
        check_equal("div_stall", 64'd1, {63'b0, div_stall});
        flush = 1'b1;
        step();
        flush = 1'b0;
        check_equal("div_stall", 64'd0, {63'b0, div_stall});
        repeat (40) step();
        check_equal("div_stall", 64'd0, {63'b0, div_stall});
        check_equal("result", held, result);   // aborted divide never wrote back

        is_div_d = 1'b1;
        stall_d  = 1'b1;
        step();
        step();
        check_equal("div_stall", 64'd0, {63'b0, div_stall});
        is_div_d = 1'b0;
        stall_d  = 1'b0;
        step();
        check_equal("div_stall", 64'd0, {63'b0, div_stall});

        run_div(alu_signed_div, 32'h8765_4321, 32'h0000_1234);
        run_div(alu_unsigned_div, 32'hdead_beef, 32'h0000_0007);

        $display("Simulation PASSED");
        $finish;
    end

endmodule

// File: build.f
verilog/alu_pkg.sv
verilog/alu_simple.sv
verilog/div_radix2.sv
verilog/mult_pipe.sv
verilog/exec_alu.sv
verification/exec_alu_tb.sv

// File: Bender.yml
package:
  name: exec_alu

sources:
  - verilog/alu_pkg.sv
  - verilog/alu_simple.sv
  - verilog/div_radix2.sv
  - verilog/mult_pipe.sv
  - verilog/exec_alu.sv
  - target: test
    files:
      - verification/exec_alu_tb.sv
